/* decode_pkg.sv */
package decode_pkg;

    localparam int pc_width       = 32;
    localparam int reg_addr_width = 5;
    localparam int ecause_width   = 5; // msb marks an interrupt
    localparam int fifo_depth     = 8;
    localparam int fifo_ptr_width = 3;

    // exception and interrupt causes
    localparam logic [ecause_width-1:0] cause_illegal_inst = 5'h02;
    localparam logic [ecause_width-1:0] cause_int_soft_s   = 5'h11;
    localparam logic [ecause_width-1:0] cause_int_soft_m   = 5'h13;
    localparam logic [ecause_width-1:0] cause_int_timer_s  = 5'h15;
    localparam logic [ecause_width-1:0] cause_int_timer_m  = 5'h17;
    localparam logic [ecause_width-1:0] cause_int_external = 5'h1B;

    // rv32i major opcodes in inst[6:0]
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        branch = 7'b1100011,
        load   = 7'b0000011,
        store  = 7'b0100011,
        system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        cls_alu,
        cls_alu_imm,
        cls_lui,
        cls_auipc,
        cls_jal,
        cls_jalr,
        cls_branch,
        cls_load,
        cls_store,
        cls_system,
        cls_illegal
    } op_class_e;

    // one slot as handed over by fetch
    typedef struct packed {
        logic [pc_width-1:0]     pc;
        logic [31:0]             inst;
        logic                    exception;
        logic [ecause_width-1:0] ecause;
    } fetch_slot_t;

    // pending interrupt levels from plic and clint
    typedef struct packed {
        logic eip;
        logic stip;
        logic mtip;
        logic ssip;
        logic msip;
    } irq_pending_t;

    // queue entry towards the rob
    typedef struct packed {
        logic [pc_width-1:0]       pc;
        logic [reg_addr_width-1:0] rs1_addr;
        logic [reg_addr_width-1:0] rs2_addr;
        logic [reg_addr_width-1:0] rd_addr;
        logic                      uses_rs1;
        logic                      uses_rs2;
        logic                      uses_rd;
        op_class_e                 op_class;
        logic [2:0]                funct3;
        logic                      alu_modifier; // inst[30]
        logic [31:0]               imm;
        logic                      exception;
        logic [ecause_width-1:0]   ecause;
    } decoded_inst_t;

endpackage

/* inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder (
    input  decode_pkg::fetch_slot_t   slot_i,
    input  decode_pkg::irq_pending_t  irq_i,
    output decode_pkg::decoded_inst_t inst_o
);

    logic [31:0]         inst;
    decode_pkg::opcode_e opcode;
    logic                illegal;

    // immediates for each format
    logic [31:0] imm_i_type;
    logic [31:0] imm_s_type;
    logic [31:0] imm_b_type;
    logic [31:0] imm_u_type;
    logic [31:0] imm_j_type;

    assign inst   = slot_i.inst;
    assign opcode = decode_pkg::opcode_e'(inst[6:0]);

    assign imm_i_type = {{20{inst[31]}}, inst[31:20]};
    assign imm_s_type = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b_type = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u_type = {inst[31:12], 12'b0};
    assign imm_j_type = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        inst_o.pc           = slot_i.pc;
        inst_o.rs1_addr     = inst[19:15];
        inst_o.rs2_addr     = inst[24:20];
        inst_o.rd_addr      = inst[11:7];
        inst_o.funct3       = inst[14:12];
        inst_o.alu_modifier = inst[30]; // sub / sra select
        inst_o.uses_rs1     = 1'b0;
        inst_o.uses_rs2     = 1'b0;
        inst_o.uses_rd      = 1'b0;
        inst_o.op_class     = decode_pkg::cls_illegal;
        inst_o.imm          = 32'b0;
        illegal             = 1'b0;

        case (opcode)
            decode_pkg::op: begin
                inst_o.op_class = decode_pkg::cls_alu;
                inst_o.uses_rs1 = 1'b1;
                inst_o.uses_rs2 = 1'b1;
                inst_o.uses_rd  = 1'b1;
            end
            decode_pkg::op_imm: begin
                inst_o.op_class = decode_pkg::cls_alu_imm;
                inst_o.uses_rs1 = 1'b1;
                inst_o.uses_rd  = 1'b1;
                inst_o.imm      = imm_i_type;
            end
            decode_pkg::lui: begin
                inst_o.op_class = decode_pkg::cls_lui;
                inst_o.uses_rd  = 1'b1;
                inst_o.imm      = imm_u_type;
            end
            decode_pkg::auipc: begin
                inst_o.op_class = decode_pkg::cls_auipc;
                inst_o.uses_rd  = 1'b1;
                inst_o.imm      = imm_u_type;
            end
            decode_pkg::jal: begin
                inst_o.op_class = decode_pkg::cls_jal;
                inst_o.uses_rd  = 1'b1;
                inst_o.imm      = imm_j_type;
            end
            decode_pkg::jalr: begin
                inst_o.op_class = decode_pkg::cls_jalr;
                inst_o.uses_rs1 = 1'b1;
                inst_o.uses_rd  = 1'b1;
                inst_o.imm      = imm_i_type;
            end
            decode_pkg::branch: begin
                inst_o.op_class = decode_pkg::cls_branch;
                inst_o.uses_rs1 = 1'b1;
                inst_o.uses_rs2 = 1'b1;
                inst_o.imm      = imm_b_type;
            end
            decode_pkg::load: begin
                inst_o.op_class = decode_pkg::cls_load;
                inst_o.uses_rs1 = 1'b1;
                inst_o.uses_rd  = 1'b1;
                inst_o.imm      = imm_i_type;
            end
            decode_pkg::store: begin
                inst_o.op_class = decode_pkg::cls_store;
                inst_o.uses_rs1 = 1'b1;
                inst_o.uses_rs2 = 1'b1;
                inst_o.imm      = imm_s_type;
            end
            decode_pkg::system: begin
                inst_o.op_class = decode_pkg::cls_system;
                inst_o.imm      = imm_i_type; // funct12 field
            end
            default: begin
                illegal = 1'b1;
            end
        endcase

        // fetch fault beats illegal opcode
        if (slot_i.exception) begin
            inst_o.exception = 1'b1;
            inst_o.ecause    = slot_i.ecause;
        end else if (illegal) begin
            inst_o.exception = 1'b1;
            inst_o.ecause    = decode_pkg::cause_illegal_inst;
        end else begin
            inst_o.exception = 1'b0;
            inst_o.ecause    = '0;
        end

        // pending interrupt overrides everything above
        if (irq_i.eip) begin
            inst_o.exception = 1'b1;
            inst_o.ecause    = decode_pkg::cause_int_external;
        end else if (irq_i.stip) begin
            inst_o.exception = 1'b1;
            inst_o.ecause    = decode_pkg::cause_int_timer_s;
        end else if (irq_i.mtip) begin
            inst_o.exception = 1'b1;
            inst_o.ecause    = decode_pkg::cause_int_timer_m;
        end else if (irq_i.ssip) begin
            inst_o.exception = 1'b1;
            inst_o.ecause    = decode_pkg::cause_int_soft_s;
        end else if (irq_i.msip) begin
            inst_o.exception = 1'b1;
            inst_o.ecause    = decode_pkg::cause_int_soft_m;
        end
    end

endmodule

/* dual_issue_fifo.sv */
`timescale 1ns/100ps

module dual_issue_fifo (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      flush_i,
    input  logic                      wr_valid_first_i,
    input  logic                      wr_valid_second_i,
    input  decode_pkg::decoded_inst_t wdata_first_i,
    input  decode_pkg::decoded_inst_t wdata_second_i,
    input  logic                      rd_ready_first_i,
    input  logic                      rd_ready_second_i,
    output decode_pkg::decoded_inst_t rdata_first_o,
    output decode_pkg::decoded_inst_t rdata_second_o,
    output logic                      has_one_free_o,
    output logic                      has_two_free_o,
    output logic                      has_one_o,
    output logic                      has_two_o
);

    decode_pkg::decoded_inst_t mem [decode_pkg::fifo_depth];

    logic [decode_pkg::fifo_ptr_width-1:0] head;
    logic [decode_pkg::fifo_ptr_width-1:0] tail;
    logic [decode_pkg::fifo_ptr_width-1:0] head_next;
    logic [decode_pkg::fifo_ptr_width-1:0] tail_next;
    logic [decode_pkg::fifo_ptr_width:0]   count; // 0 .. fifo_depth
    logic [decode_pkg::fifo_ptr_width:0]   count_next;

    logic wr_first;
    logic wr_second;
    logic rd_first;
    logic rd_second;

    // occupancy thresholds
    assign has_one_free_o = count <= (decode_pkg::fifo_ptr_width + 1)'(decode_pkg::fifo_depth - 1);
    assign has_two_free_o = count <= (decode_pkg::fifo_ptr_width + 1)'(decode_pkg::fifo_depth - 2);
    assign has_one_o      = count != '0;
    assign has_two_o      = count > (decode_pkg::fifo_ptr_width + 1)'(1);

    // second lane only moves together with the first
    assign wr_first  = wr_valid_first_i & has_one_free_o;
    assign wr_second = wr_valid_first_i & wr_valid_second_i & has_two_free_o;
    assign rd_first  = rd_ready_first_i & has_one_o;
    assign rd_second = rd_ready_first_i & rd_ready_second_i & has_two_o;

    always_comb begin
        head_next  = head;
        tail_next  = tail;
        count_next = count;
        if (wr_second) begin
            tail_next = tail + decode_pkg::fifo_ptr_width'(2);
        end else if (wr_first) begin
            tail_next = tail + decode_pkg::fifo_ptr_width'(1);
        end
        if (rd_second) begin
            head_next = head + decode_pkg::fifo_ptr_width'(2);
        end else if (rd_first) begin
            head_next = head + decode_pkg::fifo_ptr_width'(1);
        end
        count_next = count
                   + (decode_pkg::fifo_ptr_width + 1)'(wr_first)
                   + (decode_pkg::fifo_ptr_width + 1)'(wr_second)
                   - (decode_pkg::fifo_ptr_width + 1)'(rd_first)
                   - (decode_pkg::fifo_ptr_width + 1)'(rd_second);
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head_next;
            tail  <= tail_next;
            count <= count_next;
        end
    end

    // entry array with two write ports
    always_ff @(posedge clk_i) begin
        if (wr_first) begin
            mem[tail] <= wdata_first_i;
        end
        if (wr_second) begin
            mem[tail + decode_pkg::fifo_ptr_width'(1)] <= wdata_second_i;
        end
    end

    assign rdata_first_o  = mem[head];
    assign rdata_second_o = mem[head + decode_pkg::fifo_ptr_width'(1)];

endmodule

/* decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic                      clk_i,
    input  logic                      rst_i,

    // fetch side
    input  decode_pkg::fetch_slot_t   slot_first_i,
    input  decode_pkg::fetch_slot_t   slot_second_i,
    input  logic                      fetch_valid_first_i,
    input  logic                      fetch_valid_second_i,

    // rob side
    input  logic                      rob_ready_first_i,
    input  logic                      rob_ready_second_i,

    // exception control
    input  logic                      global_trap_i,
    input  logic                      global_wfi_i,
    input  logic                      global_predict_miss_i,
    input  logic                      global_ret_i,
    input  decode_pkg::irq_pending_t  irq_i,

    output logic                      fetch_ready_single_o,
    output logic                      fetch_ready_double_o,
    output logic                      rob_valid_first_o,
    output logic                      rob_valid_second_o,
    output decode_pkg::decoded_inst_t rob_inst_first_o,
    output decode_pkg::decoded_inst_t rob_inst_second_o
);

    decode_pkg::decoded_inst_t dec_first;
    decode_pkg::decoded_inst_t dec_second;
    logic flush;
    logic has_one_free;
    logic has_two_free;

    inst_decoder u_dec_first (
        .slot_i (slot_first_i),
        .irq_i  (irq_i),
        .inst_o (dec_first)
    );

    inst_decoder u_dec_second (
        .slot_i (slot_second_i),
        .irq_i  (irq_i),
        .inst_o (dec_second)
    );

    assign flush = global_trap_i | global_predict_miss_i | global_ret_i; // redirect of any kind

    dual_issue_fifo u_fifo (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .flush_i           (flush),
        .wr_valid_first_i  (fetch_valid_first_i),
        .wr_valid_second_i (fetch_valid_second_i),
        .wdata_first_i     (dec_first),
        .wdata_second_i    (dec_second),
        .rd_ready_first_i  (rob_ready_first_i),
        .rd_ready_second_i (rob_ready_second_i),
        .rdata_first_o     (rob_inst_first_o),
        .rdata_second_o    (rob_inst_second_o),
        .has_one_free_o    (has_one_free),
        .has_two_free_o    (has_two_free),
        .has_one_o         (rob_valid_first_o),
        .has_two_o         (rob_valid_second_o)
    );

    // fetch stalls while waiting for an interrupt
    assign fetch_ready_single_o = has_one_free & ~global_wfi_i;
    assign fetch_ready_double_o = has_two_free & ~global_wfi_i;

endmodule

/* tb_decode_tasks.svh */
task automatic check_value(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        $display("TESTS FAILED");
        $fatal(1);
    end
endtask

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// random word with one of the ten legal major opcodes
function automatic logic [31:0] rand_inst(input int idx);
    logic [6:0] opcodes [10] = '{7'h33, 7'h13, 7'h37, 7'h17, 7'h6f,
                                 7'h67, 7'h63, 7'h03, 7'h23, 7'h73};
    logic [31:0] r;
    r = lcg_next();
    return {r[31:7], opcodes[idx % 10]};
endfunction

task automatic drive_idle();
    fetch_valid_first  = 1'b0;
    fetch_valid_second = 1'b0;
    slot_first  = '0;
    slot_second = '0;
endtask

task automatic drive_pair(input logic vf, input logic vs);
    slot_first  = '{pc: lcg_next(), inst: rand_inst(lcg_next() >> 8), exception: 1'b0, ecause: '0};
    slot_second = '{pc: lcg_next(), inst: rand_inst(lcg_next() >> 8), exception: 1'b0, ecause: '0};
    fetch_valid_first  = vf;
    fetch_valid_second = vs;
endtask

// checks at mid cycle and then tracks what the next edge writes and pops
task automatic advance_cycle();
    int n;
    @(negedge clk);
    n = exp_q.size();
    check_value("rob_valid_first_o", rob_valid_first, n >= 1);
    check_value("rob_valid_second_o", rob_valid_second, n >= 2);
    check_value("fetch_ready_single_o", fetch_ready_single, n <= 7 && !wfi);
    check_value("fetch_ready_double_o", fetch_ready_double, n <= 6 && !wfi);
    if (rob_ready_first && n >= 1) check_value("rob_inst_first_o", rob_inst_first, exp_q[0]);
    if (rob_ready_first && rob_ready_second && n >= 2)
        check_value("rob_inst_second_o", rob_inst_second, exp_q[1]);
    if (fetch_valid_first && n <= 7) exp_q.push_back(ref_decode(slot_first, irq));
    if (fetch_valid_first && fetch_valid_second && n <= 6)
        exp_q.push_back(ref_decode(slot_second, irq));
    if (rob_ready_first && n >= 1) void'(exp_q.pop_front());
    if (rob_ready_first && rob_ready_second && n >= 2) void'(exp_q.pop_front());
    if (trap || predict_miss || ret) exp_q.delete(); // flush wins over writes
    @(posedge clk);
    #1;
endtask

task automatic drain();
    drive_idle();
    {rob_ready_first, rob_ready_second} = 2'b11;
    while (exp_q.size() != 0) advance_cycle();
endtask

task automatic test_single_decode();
    {rob_ready_first, rob_ready_second} = 2'b11;
    for (int i = 0; i < 10; i++) begin
        drive_pair(1'b1, 1'b0);
        slot_first.inst = rand_inst(i);
        advance_cycle();
        drive_idle();
        advance_cycle();
    end
    drain();
endtask

task automatic test_exceptions();
    drive_pair(1'b1, 1'b0);
    slot_first.inst[6:0] = 7'h7f; // not an rv32i opcode
    advance_cycle();
    drive_idle();
    #10 check_value("rob_inst_first_o.ecause", rob_inst_first.ecause, 5'h02);
    check_value("rob_inst_first_o.exception", rob_inst_first.exception, 1'b1);
    advance_cycle();
    drive_pair(1'b1, 1'b0);
    slot_first.exception = 1'b1;
    slot_first.ecause    = 5'h01;
    advance_cycle();
    drive_idle();
    #10 check_value("rob_inst_first_o.ecause", rob_inst_first.ecause, 5'h01);
    drain();
endtask

task automatic test_interrupt_priority();
    logic [4:0] pend [6]  = '{5'b11111, 5'b01111, 5'b00111, 5'b00011, 5'b00001, 5'b01001};
    logic [4:0] cause [6] = '{5'h1b, 5'h15, 5'h17, 5'h11, 5'h13, 5'h15};
    for (int i = 0; i < 6; i++) begin
        drive_pair(1'b1, 1'b1);
        irq = pend[i];
        advance_cycle();
        drive_idle();
        irq = '0;
        #10 check_value("rob_inst_first_o.ecause", rob_inst_first.ecause, cause[i]);
        check_value("rob_inst_second_o.ecause", rob_inst_second.ecause, cause[i]);
        check_value("rob_inst_second_o.exception", rob_inst_second.exception, 1'b1);
        advance_cycle();
    end
    drain();
endtask

task automatic test_dual_stream();
    logic [31:0] r;
    int n;
    for (int i = 0; i < 250; i++) begin
        r = lcg_next();
        n = exp_q.size();
        rob_ready_first  = r[20];
        rob_ready_second = r[20] & r[21];
        drive_pair(r[16] && n <= 7, r[16] && r[17] && n <= 6); // valid only under ready
        advance_cycle();
    end
    drain();
endtask

task automatic test_full_and_wfi();
    {rob_ready_first, rob_ready_second} = 2'b00;
    for (int i = 0; i < 10; i++) begin
        drive_pair(exp_q.size() <= 7, 1'b0);
        advance_cycle();
    end
    drive_idle();
    check_value("fetch_ready_single_o", fetch_ready_single, 1'b0);
    check_value("fetch_ready_double_o", fetch_ready_double, 1'b0);
    drain();
    wfi = 1'b1;
    advance_cycle();
    check_value("fetch_ready_single_o", fetch_ready_single, 1'b0);
    check_value("fetch_ready_double_o", fetch_ready_double, 1'b0);
    wfi = 1'b0;
    advance_cycle();
endtask

task automatic test_flush();
    for (int src = 0; src < 3; src++) begin
        {rob_ready_first, rob_ready_second} = 2'b00;
        repeat (3) begin
            drive_pair(1'b1, 1'b0);
            advance_cycle();
        end
        drive_idle();
        {trap, predict_miss, ret} = 3'b100 >> src;
        advance_cycle();
        {trap, predict_miss, ret} = 3'b000;
        #10 check_value("rob_valid_first_o", rob_valid_first, 1'b0);
        check_value("rob_valid_second_o", rob_valid_second, 1'b0);
        advance_cycle();
    end
endtask

/* tb_decode_stage.sv */
`timescale 1ns/100ps

module tb_decode_stage;

    localparam int clk_period = 100;
    localparam int max_cycles = 2000; // tests take roughly 600

    logic clk;
    logic rst;
    decode_pkg::fetch_slot_t   slot_first;
    decode_pkg::fetch_slot_t   slot_second;
    logic fetch_valid_first;
    logic fetch_valid_second;
    logic rob_ready_first;
    logic rob_ready_second;
    logic trap;
    logic wfi;
    logic predict_miss;
    logic ret;
    decode_pkg::irq_pending_t  irq;
    logic fetch_ready_single;
    logic fetch_ready_double;
    logic rob_valid_first;
    logic rob_valid_second;
    decode_pkg::decoded_inst_t rob_inst_first;
    decode_pkg::decoded_inst_t rob_inst_second;

    decode_pkg::decoded_inst_t exp_q[$]; // expected entries with the oldest first
    logic [31:0] lcg_state = 32'd92047;
    int cycles = 0;

    decode_stage u_dut (
        .clk_i                 (clk),
        .rst_i                 (rst),
        .slot_first_i          (slot_first),
        .slot_second_i         (slot_second),
        .fetch_valid_first_i   (fetch_valid_first),
        .fetch_valid_second_i  (fetch_valid_second),
        .rob_ready_first_i     (rob_ready_first),
        .rob_ready_second_i    (rob_ready_second),
        .global_trap_i         (trap),
        .global_wfi_i          (wfi),
        .global_predict_miss_i (predict_miss),
        .global_ret_i          (ret),
        .irq_i                 (irq),
        .fetch_ready_single_o  (fetch_ready_single),
        .fetch_ready_double_o  (fetch_ready_double),
        .rob_valid_first_o     (rob_valid_first),
        .rob_valid_second_o    (rob_valid_second),
        .rob_inst_first_o      (rob_inst_first),
        .rob_inst_second_o     (rob_inst_second)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout, the tests did not finish within %0d cycles", max_cycles);
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    // expected decode of one slot from the rv32i encodings
    function automatic decode_pkg::decoded_inst_t ref_decode(
        input decode_pkg::fetch_slot_t  s,
        input decode_pkg::irq_pending_t p
    );
        decode_pkg::decoded_inst_t d;
        logic [31:0] w;
        logic [31:0] imm_i;
        logic [2:0]  use_bits; // rs1 rs2 rd
        logic        bad;
        w        = s.inst;
        imm_i    = 32'($signed(w[31:20]));
        use_bits = 3'b000;
        bad      = 1'b0;
        d.pc           = s.pc;
        d.rs1_addr     = w[19:15];
        d.rs2_addr     = w[24:20];
        d.rd_addr      = w[11:7];
        d.funct3       = w[14:12];
        d.alu_modifier = w[30];
        d.imm          = 32'h0;
        d.op_class     = decode_pkg::cls_illegal;
        case (w[6:0])
            7'h33: begin
                d.op_class = decode_pkg::cls_alu;
                use_bits   = 3'b111;
            end
            7'h13: begin
                d.op_class = decode_pkg::cls_alu_imm;
                use_bits   = 3'b101;
                d.imm      = imm_i;
            end
            7'h37: begin
                d.op_class = decode_pkg::cls_lui;
                use_bits   = 3'b001;
                d.imm      = {w[31:12], 12'h0};
            end
            7'h17: begin
                d.op_class = decode_pkg::cls_auipc;
                use_bits   = 3'b001;
                d.imm      = {w[31:12], 12'h0};
            end
            7'h6f: begin
                d.op_class = decode_pkg::cls_jal;
                use_bits   = 3'b001;
                d.imm      = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            end
            7'h67: begin
                d.op_class = decode_pkg::cls_jalr;
                use_bits   = 3'b101;
                d.imm      = imm_i;
            end
            7'h63: begin
                d.op_class = decode_pkg::cls_branch;
                use_bits   = 3'b110;
                d.imm      = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
            end
            7'h03: begin
                d.op_class = decode_pkg::cls_load;
                use_bits   = 3'b101;
                d.imm      = imm_i;
            end
            7'h23: begin
                d.op_class = decode_pkg::cls_store;
                use_bits   = 3'b110;
                d.imm      = 32'($signed({w[31:25], w[11:7]}));
            end
            7'h73: begin
                d.op_class = decode_pkg::cls_system;
                d.imm      = imm_i;
            end
            default: bad = 1'b1;
        endcase
        {d.uses_rs1, d.uses_rs2, d.uses_rd} = use_bits;
        d.exception = s.exception | bad;
        d.ecause    = s.exception ? s.ecause : (bad ? 5'h02 : 5'h00);
        if (p.eip)       {d.exception, d.ecause} = {1'b1, 5'h1b};
        else if (p.stip) {d.exception, d.ecause} = {1'b1, 5'h15};
        else if (p.mtip) {d.exception, d.ecause} = {1'b1, 5'h17};
        else if (p.ssip) {d.exception, d.ecause} = {1'b1, 5'h11};
        else if (p.msip) {d.exception, d.ecause} = {1'b1, 5'h13};
        return d;
    endfunction

    `include "tb_decode_tasks.svh"

    initial begin
        rst = 1'b1;
        drive_idle();
        rob_ready_first  = 1'b0;
        rob_ready_second = 1'b0;
        trap             = 1'b0;
        wfi              = 1'b0;
        predict_miss     = 1'b0;
        ret              = 1'b0;
        irq              = '0;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        test_single_decode();
        test_exceptions();
        test_interrupt_priority();
        test_dual_stream();
        test_full_and_wfi();
        test_flush();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* project.f */
decode_pkg.sv
inst_decoder.sv
dual_issue_fifo.sv
decode_stage.sv
tb_decode_stage.sv
